// File: build.f
src/raster_pkg.sv
src/fb_pkg.sv
src/triangle_setup.sv
src/setup_fifo.sv
src/edge_walker.sv
src/rasterizer.sv
tb/tb_rasterizer.sv

// File: src/edge_walker.sv
/* edge walker: scans each bounding box in raster order, one pixel per clock,
   and emits framebuffer writes for covered pixels. */
`timescale 1ns/1ps

module edge_walker (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_valid,
    input  logic [raster_pkg::RECORD_WIDTH-1:0] i_record,
    output logic                                o_pop,
    output logic [fb_pkg::ADDRWIDTH-1:0]        o_fb_addr,
    output logic                                o_fb_write_en,
    output logic [fb_pkg::DEPTHWIDTH-1:0]       o_fb_depth,
    output logic [fb_pkg::COLORWIDTH-1:0]       o_fb_color,
    output logic                                o_finished
);
    import fb_pkg::*;

    // fields of the record at the FIFO head.
    logic [raster_pkg::BBWIDTH-1:0] w_x0, w_y0, w_x1, w_y1;
    logic signed [raster_pkg::EDGE_WIDTH-1:0] w_edge[3];
    logic signed [raster_pkg::DELTAWIDTH-1:0] w_sx[3];
    logic signed [raster_pkg::DELTAWIDTH-1:0] w_sy[3];
    logic [raster_pkg::DATAWIDTH-1:0] w_depth;
    logic [raster_pkg::IDWIDTH-1:0] w_id;
    logic w_last, w_empty;

    walk_state_e r_state;
    logic [raster_pkg::BBWIDTH-1:0] r_x, r_y, r_x0, r_x1, r_y1;
    logic signed [raster_pkg::EDGE_WIDTH-1:0] r_edge[3]; // value at the current pixel.
    logic signed [raster_pkg::EDGE_WIDTH-1:0] r_row[3];  // value at the row start.
    logic signed [raster_pkg::DELTAWIDTH-1:0] r_sx[3];
    logic signed [raster_pkg::DELTAWIDTH-1:0] r_sy[3];
    logic [ADDRWIDTH-1:0] r_addr, r_row_addr;
    logic [DEPTHWIDTH-1:0] r_depth;
    logic [raster_pkg::IDWIDTH-1:0] r_id;
    logic r_last;

    logic w_covered, w_row_end, w_box_end;

    assign {w_x0, w_y0, w_x1, w_y1,
            w_edge[0], w_edge[1], w_edge[2],
            w_sx[0], w_sx[1], w_sx[2],
            w_sy[0], w_sy[1], w_sy[2],
            w_depth, w_id, w_last, w_empty} = i_record;

    assign w_covered = (r_edge[0] >= 0) && (r_edge[1] >= 0) && (r_edge[2] >= 0);
    assign w_row_end = (r_x == r_x1);
    assign w_box_end = w_row_end && (r_y == r_y1);

    // ########################################
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= IDLE;
            o_fb_write_en <= 1'b0;
        end else begin
            case (r_state)
                IDLE:
                    if (i_valid)
                        r_state <= LOAD;
                LOAD:
                    if (!w_empty)
                        r_state <= SCAN;
                    else if (w_last)
                        r_state <= DONE;
                    else
                        r_state <= IDLE;
                SCAN:
                    if (w_box_end) begin
                        if (r_last)
                            r_state <= DONE;
                        else
                            r_state <= IDLE;
                    end
                default: r_state <= IDLE; // DONE lasts one cycle.
            endcase
            o_fb_write_en <= (r_state == SCAN) && w_covered;
        end
    end

    always_ff @(posedge clk) begin
        o_fb_addr <= r_addr;
        o_fb_depth <= r_depth;
        o_fb_color <= r_id[COLORWIDTH-1:0];
        case (r_state)
            LOAD: begin
                r_x <= w_x0;
                r_y <= w_y0;
                r_x0 <= w_x0;
                r_x1 <= w_x1;
                r_y1 <= w_y1;
                r_addr <= {w_y0, w_x0}; // 32 columns, so y * 32 + x.
                r_row_addr <= {w_y0, w_x0};
                for (int i = 0; i < 3; i++) begin
                    r_edge[i] <= w_edge[i];
                    r_row[i] <= w_edge[i];
                    r_sx[i] <= w_sx[i];
                    r_sy[i] <= w_sy[i];
                end
                r_depth <= w_depth;
                r_id <= w_id;
                r_last <= w_last;
            end
            SCAN:
                if (w_row_end) begin
                    r_x <= r_x0;
                    r_y <= r_y + 1'b1;
                    r_addr <= r_row_addr + ADDRWIDTH'(raster_pkg::SCREEN_WIDTH);
                    r_row_addr <= r_row_addr + ADDRWIDTH'(raster_pkg::SCREEN_WIDTH);
                    for (int i = 0; i < 3; i++) begin
                        r_edge[i] <= r_row[i] + r_sy[i];
                        r_row[i] <= r_row[i] + r_sy[i];
                    end
                end else begin
                    r_x <= r_x + 1'b1;
                    r_addr <= r_addr + 1'b1;
                    for (int i = 0; i < 3; i++)
                        r_edge[i] <= r_edge[i] + r_sx[i];
                end
            default: ;
        endcase
    end

    assign o_pop = (r_state == LOAD);
    assign o_finished = (r_state == DONE);

    a_write_in_scan: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_fb_write_en |-> ($past(r_state) == SCAN));

endmodule

// File: src/fb_pkg.sv
/* framebuffer write widths and the edge walker FSM states. */
package fb_pkg;

    localparam int ADDRWIDTH = 10;  // y * 32 + x.
    localparam int DEPTHWIDTH = 8;
    localparam int COLORWIDTH = 4;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        SCAN,
        DONE
    } walk_state_e;

endpackage

// File: src/raster_pkg.sv
/* geometry and screen sizes, triangle id width, setup record layout and the
   setup FSM states. */
package raster_pkg;

    localparam int DATAWIDTH = 8;              // signed vertex coordinate.
    localparam int DELTAWIDTH = DATAWIDTH + 1; // difference of two coordinates.
    localparam int SCREEN_WIDTH = 32;
    localparam int SCREEN_HEIGHT = 32;
    localparam int BBWIDTH = $clog2(SCREEN_WIDTH);
    localparam int EDGE_WIDTH = 20;
    localparam int IDWIDTH = 4;
    localparam int FIFO_DEPTH = 4;

    // ########################################
    // record fields from the msb down are box x0 y0 x1 y1, three edge start
    // values, three x steps, three y steps, depth, id, last and empty.
    localparam int RECORD_WIDTH = 4 * BBWIDTH + 3 * EDGE_WIDTH + 6 * DELTAWIDTH
                                + DATAWIDTH + IDWIDTH + 2;

    typedef enum logic [1:0] {
        IDLE,
        PRODUCT,
        AREA,
        PUSH
    } setup_state_e;

endpackage

// File: src/rasterizer.sv
/* rasterizer top: triangle setup, record FIFO and edge walker. */
`timescale 1ns/1ps

module rasterizer (
    input  logic                                    clk,
    input  logic                                    i_arst_n,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v0_x, i_v0_y, i_v0_z,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v1_x, i_v1_y, i_v1_z,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v2_x, i_v2_y, i_v2_z,
    input  logic                                    i_triangle_dv,
    input  logic                                    i_triangle_last,
    output logic                                    o_ready,
    output logic [fb_pkg::ADDRWIDTH-1:0]            o_fb_addr,
    output logic                                    o_fb_write_en,
    output logic [fb_pkg::DEPTHWIDTH-1:0]           o_fb_depth,
    output logic [fb_pkg::COLORWIDTH-1:0]           o_fb_color,
    output logic                                    o_finished
);
    import raster_pkg::*;

    logic w_push, w_full;
    logic [RECORD_WIDTH-1:0] w_push_record;
    logic w_rec_valid, w_pop;
    logic [RECORD_WIDTH-1:0] w_pop_record;

    // ########################################
    triangle_setup u_setup (
        .clk             (clk),
        .i_arst_n        (i_arst_n),
        .i_v0_x          (i_v0_x),
        .i_v0_y          (i_v0_y),
        .i_v0_z          (i_v0_z),
        .i_v1_x          (i_v1_x),
        .i_v1_y          (i_v1_y),
        .i_v1_z          (i_v1_z),
        .i_v2_x          (i_v2_x),
        .i_v2_y          (i_v2_y),
        .i_v2_z          (i_v2_z),
        .i_triangle_dv   (i_triangle_dv),
        .i_triangle_last (i_triangle_last),
        .i_full          (w_full),
        .o_ready         (o_ready),
        .o_push          (w_push),
        .o_record        (w_push_record)
    );

    setup_fifo u_fifo (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_push   (w_push),
        .i_record (w_push_record),
        .i_pop    (w_pop),
        .o_full   (w_full),
        .o_valid  (w_rec_valid),
        .o_record (w_pop_record)
    );

    edge_walker u_walker (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_valid       (w_rec_valid),
        .i_record      (w_pop_record),
        .o_pop         (w_pop),
        .o_fb_addr     (o_fb_addr),
        .o_fb_write_en (o_fb_write_en),
        .o_fb_depth    (o_fb_depth),
        .o_fb_color    (o_fb_color),
        .o_finished    (o_finished)
    );

endmodule

// File: src/setup_fifo.sv
/* four-entry FIFO of setup records between triangle setup and edge walker. */
`timescale 1ns/1ps

module setup_fifo (
    input  logic                                clk,
    input  logic                                i_arst_n,
    input  logic                                i_push,
    input  logic [raster_pkg::RECORD_WIDTH-1:0] i_record,
    input  logic                                i_pop,
    output logic                                o_full,
    output logic                                o_valid,
    output logic [raster_pkg::RECORD_WIDTH-1:0] o_record
);
    import raster_pkg::*;

    logic [RECORD_WIDTH-1:0] r_mem[FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0] r_wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] r_rd_ptr;
    logic [$clog2(FIFO_DEPTH + 1)-1:0] r_count;

    always_ff @(posedge clk) begin
        if (i_push)
            r_mem[r_wr_ptr] <= i_record;
    end

    // pointers wrap on their own, depth is a power of two.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count <= '0;
        end else begin
            if (i_push)
                r_wr_ptr <= r_wr_ptr + 1'b1;
            if (i_pop)
                r_rd_ptr <= r_rd_ptr + 1'b1;
            r_count <= r_count + i_push - i_pop;
        end
    end

    assign o_full = (r_count == FIFO_DEPTH);
    assign o_valid = (r_count != 0);
    assign o_record = r_mem[r_rd_ptr];

    // ########################################
    a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_pop |-> o_valid);

    a_no_push_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_push |-> !o_full);

endmodule

// File: src/triangle_setup.sv
/* triangle setup: clipped bounding box, edge start values and steps, flat depth,
   and culling of back-facing, degenerate and off-screen triangles. */
`timescale 1ns/1ps

module triangle_setup (
    input  logic                                    clk,
    input  logic                                    i_arst_n,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v0_x, i_v0_y, i_v0_z,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v1_x, i_v1_y, i_v1_z,
    input  logic signed [raster_pkg::DATAWIDTH-1:0] i_v2_x, i_v2_y, i_v2_z,
    input  logic                                    i_triangle_dv,
    input  logic                                    i_triangle_last,
    input  logic                                    i_full,
    output logic                                    o_ready,
    output logic                                    o_push,
    output logic [raster_pkg::RECORD_WIDTH-1:0]     o_record
);
    import raster_pkg::*;

    setup_state_e r_state;
    logic [IDWIDTH-1:0] r_id;

    logic signed [DATAWIDTH-1:0] r_vx[3];
    logic signed [DATAWIDTH-1:0] r_vy[3];
    logic signed [DATAWIDTH-1:0] r_vz[3];
    logic r_last;

    logic signed [DATAWIDTH-1:0] c_min_x, c_max_x, c_min_y, c_max_y, c_min_z;
    logic signed [DATAWIDTH-1:0] c_x0, c_x1, c_y0, c_y1;
    logic c_empty;
    logic signed [DELTAWIDTH-1:0] c_dy[3];  // step in x.
    logic signed [DELTAWIDTH-1:0] c_dxs[3]; // step in y.
    logic signed [DELTAWIDTH-1:0] c_ox[3];
    logic signed [DELTAWIDTH-1:0] c_oy[3];
    logic signed [DELTAWIDTH-1:0] c_ax, c_ay;

    logic [BBWIDTH-1:0] r_bx0, r_by0, r_bx1, r_by1;
    logic r_empty;
    logic signed [DELTAWIDTH-1:0] r_dy[3];
    logic signed [DELTAWIDTH-1:0] r_dxs[3];
    logic signed [EDGE_WIDTH-1:0] r_pa[3];
    logic signed [EDGE_WIDTH-1:0] r_pb[3];
    logic signed [EDGE_WIDTH-1:0] r_ap[2];
    logic signed [EDGE_WIDTH-1:0] r_edge[3];
    logic [fb_pkg::DEPTHWIDTH-1:0] r_depth;
    logic r_cull;

    function automatic logic signed [DATAWIDTH-1:0] min3(
        input logic signed [DATAWIDTH-1:0] a, b, c);
        logic signed [DATAWIDTH-1:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [DATAWIDTH-1:0] max3(
        input logic signed [DATAWIDTH-1:0] a, b, c);
        logic signed [DATAWIDTH-1:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // ########################################
    // box, clipping and edge differences.
    always_comb begin
        c_min_x = min3(r_vx[0], r_vx[1], r_vx[2]);
        c_max_x = max3(r_vx[0], r_vx[1], r_vx[2]);
        c_min_y = min3(r_vy[0], r_vy[1], r_vy[2]);
        c_max_y = max3(r_vy[0], r_vy[1], r_vy[2]);
        c_min_z = min3(r_vz[0], r_vz[1], r_vz[2]);
        c_x0 = (c_min_x < 0) ? '0 : c_min_x;
        c_y0 = (c_min_y < 0) ? '0 : c_min_y;
        c_x1 = (c_max_x > SCREEN_WIDTH - 1) ? DATAWIDTH'(SCREEN_WIDTH - 1) : c_max_x;
        c_y1 = (c_max_y > SCREEN_HEIGHT - 1) ? DATAWIDTH'(SCREEN_HEIGHT - 1) : c_max_y;
        c_empty = (c_x0 > c_x1) || (c_y0 > c_y1);
        for (int i = 0; i < 3; i++) begin
            c_dy[i] = r_vy[(i + 1) % 3] - r_vy[i];
            c_dxs[i] = r_vx[i] - r_vx[(i + 1) % 3];
            c_ox[i] = c_x0 - r_vx[i];
            c_oy[i] = c_y0 - r_vy[i];
        end
        c_ax = r_vx[2] - r_vx[0]; // edge 0 evaluated at v2.
        c_ay = r_vy[2] - r_vy[0];
    end

    // ########################################
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            r_state <= IDLE;
            r_id <= '0;
        end else begin
            case (r_state)
                IDLE:
                    if (i_triangle_dv)
                        r_state <= PRODUCT;
                PRODUCT: r_state <= AREA;
                AREA: r_state <= PUSH;
                PUSH:
                    if (!i_full) begin
                        r_state <= IDLE;
                        r_id <= r_id + 1'b1; // culled triangles use up an id too.
                    end
                default: r_state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (r_state)
            IDLE:
                if (i_triangle_dv) begin
                    r_vx <= '{i_v0_x, i_v1_x, i_v2_x};
                    r_vy <= '{i_v0_y, i_v1_y, i_v2_y};
                    r_vz <= '{i_v0_z, i_v1_z, i_v2_z};
                    r_last <= i_triangle_last;
                end
            PRODUCT: begin
                for (int i = 0; i < 3; i++) begin
                    r_pa[i] <= c_ox[i] * c_dy[i];
                    r_pb[i] <= c_oy[i] * c_dxs[i];
                    r_dy[i] <= c_dy[i];
                    r_dxs[i] <= c_dxs[i];
                end
                r_ap[0] <= c_ax * c_dy[0];
                r_ap[1] <= c_ay * c_dxs[0];
                r_bx0 <= c_x0[BBWIDTH-1:0];
                r_by0 <= c_y0[BBWIDTH-1:0];
                r_bx1 <= c_x1[BBWIDTH-1:0];
                r_by1 <= c_y1[BBWIDTH-1:0];
                r_empty <= c_empty;
                r_depth <= c_min_z;
            end
            AREA: begin
                for (int i = 0; i < 3; i++)
                    r_edge[i] <= r_pa[i] + r_pb[i];
                r_cull <= r_empty || (r_ap[0] + r_ap[1] <= 0); // zero or negative area.
            end
            default: ;
        endcase
    end

    assign o_ready = (r_state == IDLE);
    // a culled last triangle still goes out, flagged empty.
    assign o_push = (r_state == PUSH) && !i_full && (!r_cull || r_last);
    assign o_record = {r_bx0, r_by0, r_bx1, r_by1,
                       r_edge[0], r_edge[1], r_edge[2],
                       r_dy[0], r_dy[1], r_dy[2],
                       r_dxs[0], r_dxs[1], r_dxs[2],
                       r_depth, r_id, r_last, r_cull};

    a_push_not_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_push |-> !i_full);

endmodule

// File: tb/tb_rasterizer.sv
/* rasterizer testbench: directed and random triangles, reference model,
   pixel write comparison and watchdog. */
`timescale 1ns/1ps

module tb_rasterizer;
    import raster_pkg::*;
    import fb_pkg::*;

    localparam int NUM_TRI = 36;
    localparam int NUM_DIRECTED = 6; // the rest are random.

    logic clk;
    logic i_arst_n;
    logic signed [DATAWIDTH-1:0] i_v0_x, i_v0_y, i_v0_z;
    logic signed [DATAWIDTH-1:0] i_v1_x, i_v1_y, i_v1_z;
    logic signed [DATAWIDTH-1:0] i_v2_x, i_v2_y, i_v2_z;
    logic i_triangle_dv, i_triangle_last;
    logic o_ready, o_fb_write_en, o_finished;
    logic [ADDRWIDTH-1:0] o_fb_addr;
    logic [DEPTHWIDTH-1:0] o_fb_depth;
    logic [COLORWIDTH-1:0] o_fb_color;

    int tri_x[NUM_TRI][3];
    int tri_y[NUM_TRI][3];
    int tri_z[NUM_TRI][3];
    logic [ADDRWIDTH-1:0] exp_addr[$];
    logic [DEPTHWIDTH-1:0] exp_depth[$];
    logic [COLORWIDTH-1:0] exp_color[$];
    int unsigned lcg_state = 36;
    int watchdog_cycles = 0;
    int streams_sent = 0;
    int finished_count = 0;

    rasterizer DUT (.*);

    always #10 clk = ~clk;

    // ########################################
    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(lcg_next() % (hi - lo + 1));
    endfunction

    function automatic int min3(input int a, input int b, input int c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int max3(input int a, input int b, input int c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    // edge i runs from vertex i to vertex i+1.
    function automatic int edge_value(input int t, input int i, input int x, input int y);
        int a;
        int b;
        a = i;
        b = (i + 1) % 3;
        return (x - tri_x[t][a]) * (tri_y[t][b] - tri_y[t][a])
             - (y - tri_y[t][a]) * (tri_x[t][b] - tri_x[t][a]);
    endfunction

    function automatic void clip_box(input int t, output int x0, output int y0,
                                     output int x1, output int y1);
        x0 = max3(min3(tri_x[t][0], tri_x[t][1], tri_x[t][2]), 0, 0);
        y0 = max3(min3(tri_y[t][0], tri_y[t][1], tri_y[t][2]), 0, 0);
        x1 = min3(max3(tri_x[t][0], tri_x[t][1], tri_x[t][2]), SCREEN_WIDTH - 1, SCREEN_WIDTH);
        y1 = min3(max3(tri_y[t][0], tri_y[t][1], tri_y[t][2]), SCREEN_HEIGHT - 1, SCREEN_HEIGHT);
    endfunction

    function automatic int box_area(input int t);
        int x0, y0, x1, y1;
        clip_box(t, x0, y0, x1, y1);
        return (x0 > x1 || y0 > y1) ? 0 : (x1 - x0 + 1) * (y1 - y0 + 1);
    endfunction

    // expected writes of triangle t in raster order. triangle t carries id t.
    function automatic void raster_ref(input int t);
        int x0, y0, x1, y1, zmin;
        bit covered;
        clip_box(t, x0, y0, x1, y1);
        if (x0 > x1 || y0 > y1)
            return;
        if (edge_value(t, 0, tri_x[t][2], tri_y[t][2]) <= 0)
            return; // back-facing or degenerate.
        zmin = min3(tri_z[t][0], tri_z[t][1], tri_z[t][2]);
        for (int y = y0; y <= y1; y++)
            for (int x = x0; x <= x1; x++) begin
                covered = 1'b1;
                for (int i = 0; i < 3; i++)
                    if (edge_value(t, i, x, y) < 0)
                        covered = 1'b0;
                if (covered) begin
                    exp_addr.push_back(ADDRWIDTH'(y * SCREEN_WIDTH + x));
                    exp_depth.push_back(DEPTHWIDTH'(zmin));
                    exp_color.push_back(COLORWIDTH'(t));
                end
            end
    endfunction

    // ########################################
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input logic [ADDRWIDTH-1:0] got,
                              input logic [ADDRWIDTH-1:0] want);
        if (got !== want)
            abort_run($sformatf("MISMATCH at %0t: fb_addr got %0d, expected %0d",
                                $time, got, want));
    endtask

    task automatic check_depth(input logic [DEPTHWIDTH-1:0] got,
                               input logic [DEPTHWIDTH-1:0] want);
        if (got !== want)
            abort_run($sformatf("MISMATCH at %0t: fb_depth got %0d, expected %0d",
                                $time, got, want));
    endtask

    task automatic check_color(input logic [COLORWIDTH-1:0] got,
                               input logic [COLORWIDTH-1:0] want);
        if (got !== want)
            abort_run($sformatf("MISMATCH at %0t: fb_color got %0d, expected %0d",
                                $time, got, want));
    endtask

    task automatic set_triangle(input int t, input int x0, input int y0, input int z0,
                                input int x1, input int y1, input int z1,
                                input int x2, input int y2, input int z2);
        tri_x[t] = '{x0, x1, x2};
        tri_y[t] = '{y0, y1, y2};
        tri_z[t] = '{z0, z1, z2};
    endtask

    // called just after a falling edge; dv goes high as soon as setup is ready.
    task automatic send_triangle(input int t, input bit last);
        while (!o_ready)
            @(negedge clk);
        i_v0_x = DATAWIDTH'(tri_x[t][0]);
        i_v0_y = DATAWIDTH'(tri_y[t][0]);
        i_v0_z = DATAWIDTH'(tri_z[t][0]);
        i_v1_x = DATAWIDTH'(tri_x[t][1]);
        i_v1_y = DATAWIDTH'(tri_y[t][1]);
        i_v1_z = DATAWIDTH'(tri_z[t][1]);
        i_v2_x = DATAWIDTH'(tri_x[t][2]);
        i_v2_y = DATAWIDTH'(tri_y[t][2]);
        i_v2_z = DATAWIDTH'(tri_z[t][2]);
        i_triangle_dv = 1'b1;
        i_triangle_last = last;
        @(negedge clk);
        i_triangle_dv = 1'b0;
        i_triangle_last = 1'b0;
        if (o_ready)
            abort_run("o_ready stayed high after a triangle was taken");
    endtask

    task automatic run_stream(input int first, input int stop);
        for (int t = first; t < stop; t++)
            raster_ref(t);
        streams_sent++;
        for (int t = first; t < stop; t++)
            send_triangle(t, t == stop - 1);
        wait (finished_count == streams_sent);
        @(negedge clk);
    endtask

    // ########################################
    always @(negedge clk) begin
        if (i_arst_n && o_fb_write_en) begin
            if (exp_addr.size() == 0)
                abort_run("framebuffer write seen when no more writes were expected");
            else begin
                check_addr(o_fb_addr, exp_addr.pop_front());
                check_depth(o_fb_depth, exp_depth.pop_front());
                check_color(o_fb_color, exp_color.pop_front());
            end
        end
        if (i_arst_n && o_finished) begin
            if (finished_count >= streams_sent)
                abort_run("o_finished pulsed more often than streams were sent");
            else if (exp_addr.size() != 0)
                abort_run($sformatf("o_finished came with %0d writes still missing",
                                    exp_addr.size()));
            else
                finished_count++;
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("the run timed out before all triangles were rasterized");
    end

    initial begin
        int budget;
        clk = 1'b0;
        i_arst_n = 1'b0;
        {i_v0_x, i_v0_y, i_v0_z, i_v1_x, i_v1_y, i_v1_z} = '0;
        {i_v2_x, i_v2_y, i_v2_z} = '0;
        i_triangle_dv = 1'b0;
        i_triangle_last = 1'b0;

        set_triangle(0, 2, 2, 40, 8, 18, 25, 20, 4, 60);     // counter-clockwise, on screen.
        set_triangle(1, 2, 2, 10, 20, 4, 10, 8, 18, 10);     // clockwise.
        set_triangle(2, 1, 1, 5, 5, 5, 5, 10, 10, 5);        // degenerate.
        set_triangle(3, 4, 20, 70, 12, 28, 90, 14, 22, 33);
        set_triangle(4, -4, -3, 50, 10, 36, 15, 36, 5, 99);  // partly off screen.
        set_triangle(5, 33, 0, 1, 34, 10, 2, 36, 2, 3);      // wholly off screen.
        for (int t = NUM_DIRECTED; t < NUM_TRI; t++)
            for (int v = 0; v < 3; v++) begin
                tri_x[t][v] = rand_range(-4, 36);
                tri_y[t][v] = rand_range(-4, 36);
                tri_z[t][v] = rand_range(0, 120);
            end
        budget = 0;
        for (int t = 0; t < NUM_TRI; t++)
            budget += box_area(t) + 10;
        watchdog_cycles = 2 * budget;

        repeat (2) @(negedge clk);
        i_arst_n = 1'b1;
        @(negedge clk);
        if (!o_ready)
            abort_run("o_ready is low after reset");
        run_stream(0, NUM_DIRECTED);   // ends on a culled last triangle.
        run_stream(NUM_DIRECTED, NUM_TRI);
        repeat (20) @(negedge clk);

        if (exp_addr.size() != 0 || finished_count != 2)
            abort_run("stream ended with writes missing or o_finished pulses not seen");
        else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
